// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = dcache_data_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) bench/dcache_model.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/dcache_model.svh ====
`ifndef DCACHE_MODEL_SVH
`define DCACHE_MODEL_SVH

////////////////////
// shadow storage
////////////////////

// one line per way and set, mirrors the ram
dcache_pkg::line_t shadow [dcache_pkg::NUM_WAYS][2**dcache_pkg::SET_BITS];

// refill copies the line, store copies enabled bytes of the word only
function automatic void apply_write(input dcache_pkg::wr_req_t w);
    int lane;
    lane = int'(w.offset) * dcache_pkg::WORD_BITS;
    for (int way = 0; way < dcache_pkg::NUM_WAYS; way++) begin
        if (w.en && w.ways[way]) begin
            if (w.replace) begin
                shadow[way][w.addr] = w.line;
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (w.bytes[b]) begin
                        shadow[way][w.addr][lane + 8*b +: 8] = w.word[8*b +: 8];
                    end
                end
            end
        end
    end
endfunction

////////////////////
// expected read
////////////////////

// way is one-hot, word taken from lane 32 * offset
function automatic dcache_pkg::rd_resp_t lookup_read(input dcache_pkg::set_addr_t s,
                                                     input dcache_pkg::way_mask_t way,
                                                     input dcache_pkg::offset_t off);
    dcache_pkg::rd_resp_t r;
    int idx;
    idx = 0;
    for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
        if (way[w]) begin
            idx = w;
        end
    end
    r.valid = 1'b1;
    r.line  = shadow[idx][s];
    r.word  = r.line[int'(off) * dcache_pkg::WORD_BITS +: dcache_pkg::WORD_BITS];
    return r;
endfunction

`endif

// ==== bench/dcache_data_tb.sv ====
`timescale 1ns/10ps

module dcache_data_tb;

    // refill 160, store 48, isolation 72, stream 32, read-write 16, mix, reset
    localparam int MIX_CYCLES      = 400;
    localparam int TEST_CYCLES     = 160 + 48 + 72 + 32 + 16 + MIX_CYCLES + 12;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 8 + 6 * 2 + 200;

    logic                 clk;
    logic                 rst;
    dcache_pkg::wr_req_t  wr;
    dcache_pkg::rd_req_t  rd;
    dcache_pkg::rd_resp_t resp;

    integer seed   = 32'h5be1_4ae1;
    int cycle      = 0;
    int errors     = 0;
    int checks     = 0;
    int tests_run  = 0;
    int tests_ok   = 0;
    int err_mark   = 0;

    // expected response and the cycle it is due in
    typedef struct packed {
        int                   due;
        dcache_pkg::rd_resp_t data;
    } expect_t;
    expect_t pending [$];

    `include "dcache_model.svh"

    dcache_data UUT (.clk(clk), .rst(rst), .wr(wr), .rd(rd), .resp(resp));

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////
    // request builders
    ////////////////////

    function automatic dcache_pkg::wr_req_t no_write();
        return '0;
    endfunction

    function automatic dcache_pkg::rd_req_t no_read();
        return '0;
    endfunction

    function automatic dcache_pkg::wr_req_t refill_req(input dcache_pkg::set_addr_t s,
                                                       input dcache_pkg::way_mask_t w,
                                                       input dcache_pkg::line_t l);
        dcache_pkg::wr_req_t r;
        r         = '0;
        r.en      = 1'b1;
        r.addr    = s;
        r.ways    = w;
        r.replace = 1'b1;
        r.line    = l;
        return r;
    endfunction

    function automatic dcache_pkg::wr_req_t store_req(input dcache_pkg::set_addr_t s,
                                                      input dcache_pkg::way_mask_t w,
                                                      input dcache_pkg::offset_t off,
                                                      input dcache_pkg::byte_mask_t m,
                                                      input dcache_pkg::word_t d);
        dcache_pkg::wr_req_t r;
        r        = '0;
        r.en     = 1'b1;
        r.addr   = s;
        r.ways   = w;
        r.offset = off;
        r.bytes  = m;
        r.word   = d;
        return r;
    endfunction

    function automatic dcache_pkg::rd_req_t read_req(input dcache_pkg::set_addr_t s,
                                                     input dcache_pkg::way_mask_t w,
                                                     input dcache_pkg::offset_t off);
        dcache_pkg::rd_req_t r;
        r.en     = 1'b1;
        r.addr   = s;
        r.way    = w;
        r.offset = off;
        return r;
    endfunction

    ////////////////////
    // random fields
    ////////////////////

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic dcache_pkg::line_t random_line();
        return {rand32(), rand32(), rand32(), rand32()};
    endfunction

    function automatic dcache_pkg::set_addr_t random_set();
        logic [31:0] r;
        r = rand32();
        return r[dcache_pkg::SET_BITS-1:0];
    endfunction

    function automatic dcache_pkg::offset_t random_offset();
        logic [31:0] r;
        r = rand32();
        return r[dcache_pkg::OFFSET_BITS-1:0];
    endfunction

    // one-hot way for reads
    function automatic dcache_pkg::way_mask_t random_way();
        logic [31:0] r;
        r = rand32();
        return r[0] ? 2'b10 : 2'b01;
    endfunction

    // either way or both for writes
    function automatic dcache_pkg::way_mask_t random_ways();
        logic [31:0] r;
        r = rand32();
        return (r[1:0] == 2'd0) ? 2'b01 : ((r[1:0] == 2'd1) ? 2'b10 : 2'b11);
    endfunction

    // never empty
    function automatic dcache_pkg::byte_mask_t random_mask();
        logic [31:0] r;
        r = rand32();
        return (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    // drive one cycle; expected read taken before the write hits the model
    task automatic step(input dcache_pkg::wr_req_t w, input dcache_pkg::rd_req_t r);
        expect_t e;
        @(posedge clk);
        wr <= w;
        rd <= r;
        if (r.en) begin
            e.due  = cycle + 2;
            e.data = lookup_read(r.addr, r.way, r.offset);
            pending.push_back(e);
        end
        apply_write(w);
    endtask

    task automatic finish_test(input string name);
        repeat (2) begin
            step(no_write(), no_read());
        end
        assert (pending.size() == 0) else begin
            $display("reads still waiting for a response after test %s", name);
            errors++;
        end
        tests_run++;
        if (errors == err_mark) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic refill_all_sets();
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 2; w++) begin
                step(refill_req(4'(s), 2'(1 << w), random_line()), no_read());
            end
        end
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 2; w++) begin
                for (int o = 0; o < 4; o++) begin
                    step(no_write(), read_req(4'(s), 2'(1 << w), 2'(o)));
                end
            end
        end
    endtask

    task automatic store_words();
        dcache_pkg::set_addr_t s;
        dcache_pkg::way_mask_t w;
        dcache_pkg::offset_t   off;
        repeat (24) begin
            s   = random_set();
            w   = random_way();
            off = random_offset();
            step(store_req(s, w, off, random_mask(), rand32()), no_read());
            // full line compare shows the other lanes untouched
            step(no_write(), read_req(s, w, random_offset()));
        end
    endtask

    task automatic isolate_ways();
        dcache_pkg::set_addr_t s;
        repeat (8) begin
            s = random_set();
            step(store_req(s, 2'b01, random_offset(), random_mask(), rand32()), no_read());
            step(no_write(), read_req(s, 2'b10, random_offset()));
            step(no_write(), read_req(s, 2'b01, random_offset()));
            step(store_req(s, 2'b10, random_offset(), random_mask(), rand32()), no_read());
            step(no_write(), read_req(s, 2'b01, random_offset()));
            step(no_write(), read_req(s, 2'b10, random_offset()));
            // dual update
            step(refill_req(s, 2'b11, random_line()), no_read());
            step(no_write(), read_req(s, 2'b01, random_offset()));
            step(no_write(), read_req(s, 2'b10, random_offset()));
        end
    endtask

    task automatic stream_reads();
        repeat (32) begin
            step(no_write(), read_req(random_set(), random_way(), random_offset()));
        end
    endtask

    task automatic read_while_writing();
        dcache_pkg::set_addr_t s;
        dcache_pkg::way_mask_t w;
        dcache_pkg::offset_t   off;
        dcache_pkg::wr_req_t   wreq;
        for (int i = 0; i < 8; i++) begin
            s    = random_set();
            w    = random_way();
            off  = random_offset();
            wreq = (i % 2 == 0) ? refill_req(s, w, random_line())
                                : store_req(s, w, off, random_mask(), rand32());
            // old line now and new line next cycle
            step(wreq, read_req(s, w, off));
            step(no_write(), read_req(s, w, off));
        end
    endtask

    task automatic random_mix();
        logic [31:0]           r;
        dcache_pkg::wr_req_t   wreq;
        dcache_pkg::rd_req_t   rreq;
        // a read strobe held through reset must not come back
        @(posedge clk);
        rst <= 1'b1;
        rd  <= read_req(random_set(), random_way(), random_offset());
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        rd  <= no_read();
        // idle after reset so any valid here is a stray response
        repeat (4) begin
            step(no_write(), no_read());
        end
        repeat (MIX_CYCLES) begin
            r    = rand32();
            wreq = no_write();
            rreq = no_read();
            if (r[0]) begin
                wreq = r[1] ? refill_req(random_set(), random_ways(), random_line())
                            : store_req(random_set(), random_ways(), random_offset(),
                                        random_mask(), rand32());
            end
            if (r[2]) begin
                rreq = read_req(random_set(), random_way(), random_offset());
            end
            step(wreq, rreq);
        end
    endtask

    ////////////////////
    // checker
    ////////////////////

    // outputs are stable by the falling edge
    always @(negedge clk) begin : compare
        expect_t head;
        logic    missing;
        logic    stray;
        missing = (pending.size() > 0) && (pending[0].due <= cycle) && !resp.valid;
        stray   = resp.valid && (pending.size() == 0);
        assert (!missing) else begin
            $display("missing response at %0t ns for a read due in cycle %0d",
                     $time, pending[0].due);
            errors++;
        end
        if (missing) begin
            head = pending.pop_front();
        end
        assert (!stray) else begin
            $display("unexpected response at %0t ns with no read pending", $time);
            errors++;
        end
        if (resp.valid && pending.size() > 0) begin
            head = pending.pop_front();
            checks++;
            assert (head.due == cycle) else begin
                $display("response at %0t ns came in the wrong cycle", $time);
                errors++;
            end
            assert (resp.line === head.data.line) else begin
                $display("FAILED at %0t ns: line expected %h, got %h",
                         $time, head.data.line, resp.line);
                errors++;
            end
            assert (resp.word === head.data.word) else begin
                $display("FAILED at %0t ns: word expected %h, got %h",
                         $time, head.data.word, resp.word);
                errors++;
            end
        end
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        rst = 1'b1;
        wr  = no_write();
        rd  = no_read();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        refill_all_sets();
        finish_test("line refill");
        store_words();
        finish_test("word store");
        isolate_ways();
        finish_test("way isolation");
        stream_reads();
        finish_test("back-to-back reads");
        read_while_writing();
        finish_test("read during write");
        random_mix();
        finish_test("random mix");
        $display("tests: %0d, passed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_ok, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+bench
verilog/dcache_pkg.sv
verilog/dcache_write_format.sv
verilog/bram_bytewrite.sv
verilog/dcache_read_select.sv
verilog/dcache_data.sv
bench/dcache_data_tb.sv

// ==== verilog/bram_bytewrite.sv ====
`timescale 1ns/10ps

module bram_bytewrite (
    input  logic                clk,
    input  dcache_pkg::ram_wr_t wr_port,
    input  dcache_pkg::set_addr_t raddr,
    output dcache_pkg::line_t   dout
);

    ////////////////////
    // storage
    ////////////////////

    // one line per set
    dcache_pkg::line_t mem [0:(2**dcache_pkg::SET_BITS)-1];

    ////////////////////
    // write port
    ////////////////////

    // untouched bytes keep their old value
    always_ff @(posedge clk) begin
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            if (wr_port.we[b]) begin
                mem[wr_port.addr][b*8 +: 8] <= wr_port.din[b*8 +: 8];
            end
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // registered every cycle
    // read-first so a same edge write is not visible yet
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

// ==== verilog/dcache_data.sv ====
`timescale 1ns/10ps

module dcache_data (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::wr_req_t  wr,
    input  dcache_pkg::rd_req_t  rd,
    output dcache_pkg::rd_resp_t resp
);

    ////////////////////
    // internal wires
    ////////////////////

    // write port per way
    dcache_pkg::ram_wr_t [dcache_pkg::NUM_WAYS-1:0] ram_wr;

    // registered line from each way
    dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] way_lines;

    ////////////////////
    // write formatting
    ////////////////////

    // refill or store hit into byte enables
    dcache_write_format u_write_format (
        .wr     (wr),
        .ram_wr (ram_wr)
    );

    ////////////////////
    // ways
    ////////////////////

    // every way reads the same set
    // the selector picks one afterwards
    for (genvar g = 0; g < dcache_pkg::NUM_WAYS; g++) begin : g_way
        bram_bytewrite u_way (
            .clk     (clk),
            .wr_port (ram_wr[g]),
            .raddr   (rd.addr),
            .dout    (way_lines[g])
        );
    end

    ////////////////////
    // read select
    ////////////////////

    // way and offset follow the ram by one cycle
    dcache_read_select u_read_select (
        .clk       (clk),
        .rst       (rst),
        .rd        (rd),
        .way_lines (way_lines),
        .resp      (resp)
    );

endmodule

// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    ////////////////////
    // cache geometry
    ////////////////////

    localparam int NUM_WAYS    = 2;
    // 16 sets per way
    localparam int SET_BITS    = 4;
    localparam int LINE_BITS   = 128;
    localparam int WORD_BITS   = 32;
    // four words per line
    localparam int OFFSET_BITS = 2;
    localparam int LINE_BYTES  = LINE_BITS / 8;

    // widths with a meaning
    typedef logic [SET_BITS-1:0]      set_addr_t;
    typedef logic [LINE_BITS-1:0]     line_t;
    typedef logic [WORD_BITS-1:0]     word_t;
    typedef logic [OFFSET_BITS-1:0]   offset_t;
    typedef logic [NUM_WAYS-1:0]      way_mask_t;
    typedef logic [WORD_BITS/8-1:0]   byte_mask_t;
    typedef logic [LINE_BYTES-1:0]    line_mask_t;

    ////////////////////
    // request and response bundles
    ////////////////////

    // replace = 1 for refill, 0 for a store hit on one word
    typedef struct packed {
        logic       en;
        set_addr_t  addr;
        way_mask_t  ways;
        logic       replace;
        offset_t    offset;
        byte_mask_t bytes;
        line_t      line;
        word_t      word;
    } wr_req_t;

    // way chosen by requester, no hit logic here
    typedef struct packed {
        logic      en;
        set_addr_t addr;
        way_mask_t way;
        offset_t   offset;
    } rd_req_t;

    typedef struct packed {
        logic  valid;
        line_t line;
        word_t word;
    } rd_resp_t;

    // one way's write port
    typedef struct packed {
        set_addr_t  addr;
        line_t      din;
        line_mask_t we;
    } ram_wr_t;

endpackage

// ==== verilog/dcache_read_select.sv ====
`timescale 1ns/10ps

module dcache_read_select (
    input  logic                                        clk,
    input  logic                                        rst,
    input  dcache_pkg::rd_req_t                         rd,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] way_lines,
    output dcache_pkg::rd_resp_t                        resp
);

    ////////////////////
    // request stage
    ////////////////////

    logic                  rd_en_q;
    dcache_pkg::way_mask_t way_q;
    dcache_pkg::offset_t   offset_q;

    // read strobe one cycle behind rd.en
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en_q <= 1'b0;
        end else begin
            rd_en_q <= rd.en;
        end
    end

    // lines up with the ram read register
    always_ff @(posedge clk) begin
        way_q    <= rd.way;
        offset_q <= rd.offset;
    end

    ////////////////////
    // way and word select
    ////////////////////

    dcache_pkg::line_t line_sel;

    // and-or mux on one-hot way
    always_comb begin
        line_sel = '0;
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            if (way_q[w]) begin
                line_sel = line_sel | way_lines[w];
            end
        end
    end

    assign resp.valid = rd_en_q;
    assign resp.line  = line_sel;
    // lane at 32 * offset
    assign resp.word  = line_sel[{offset_q, 5'b00000} +: dcache_pkg::WORD_BITS];

    ////////////////////
    // checks
    ////////////////////

    a_way_onehot: assert property (@(posedge clk) disable iff (rst)
        rd_en_q |-> $onehot(way_q))
        else $error("read issued with way mask not one-hot");

endmodule

// ==== verilog/dcache_write_format.sv ====
`timescale 1ns/10ps

module dcache_write_format (
    input  dcache_pkg::wr_req_t                            wr,
    output dcache_pkg::ram_wr_t [dcache_pkg::NUM_WAYS-1:0] ram_wr
);

    ////////////////////
    // byte enables
    ////////////////////

    dcache_pkg::line_mask_t word_mask;
    dcache_pkg::line_mask_t line_mask;

    // four byte lanes per word of offset
    assign word_mask = dcache_pkg::line_mask_t'(wr.bytes) << {wr.offset, 2'b00};

    // refill takes every byte
    assign line_mask = wr.replace ? '1 : word_mask;

    ////////////////////
    // write data
    ////////////////////

    dcache_pkg::line_t word_line;
    dcache_pkg::line_t din;

    // word into its 32-bit lane, other lanes zero
    assign word_line = dcache_pkg::line_t'(wr.word) << {wr.offset, 5'b00000};
    assign din       = wr.replace ? wr.line : word_line;

    ////////////////////
    // per way ports
    ////////////////////

    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            ram_wr[w].addr = wr.addr;
            ram_wr[w].din  = din;
            // only selected ways see enables
            if (wr.en && wr.ways[w]) begin
                ram_wr[w].we = line_mask;
            end else begin
                ram_wr[w].we = '0;
            end
        end
    end

    ////////////////////
    // request sanity
    ////////////////////

    always_comb begin
        if (wr.en) begin
            // one way, or both for a dual update
            assert (wr.ways != '0)
                else $error("write strobe with empty way mask");
            // store hit must touch at least one byte
            assert (wr.replace || wr.bytes != '0)
                else $error("word write with empty byte mask");
        end
    end

endmodule
